// ==== source/ru_pkg.sv ====
package ru_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    typedef logic [11:0] sector_t;       // 4 KB sector number
    typedef logic [15:0] byte_cnt_t;     // zero reads one byte
    typedef logic [23:0] flash_addr_t;   // 3-byte flash address
    typedef logic [31:0] crc_t;

    // ------------------------------
    // register map
    // ------------------------------
    localparam logic [1:0] REG_START_SECTOR = 2'd0;
    localparam logic [1:0] REG_BYTE_CNT     = 2'd1;
    localparam logic [1:0] REG_EXPECT_CRC   = 2'd2;
    localparam logic [1:0] REG_CTRL         = 2'd3;

    localparam int CTRL_GO     = 0;      // start a readback
    localparam int CTRL_UP2CPU = 1;      // forward bytes to host

    // ------------------------------
    // flash and crc constants
    // ------------------------------
    localparam logic [7:0] FLASH_CMD_READ = 8'h03;   // plain read, no dummy cycles
    localparam int         SECTOR_SHIFT   = 12;

    localparam crc_t CRC_POLY_REFL = 32'hedb8_8320;
    localparam crc_t CRC_INIT      = 32'hffff_ffff;  // also the final xor

    // ------------------------------
    // stage payloads
    // ------------------------------
    typedef struct packed {
        logic        valid;
        logic [1:0]  addr;
        logic [31:0] data;
    } host_wr_t;

    typedef struct packed {
        logic        valid;
        flash_addr_t addr;       // byte address, already sector aligned
        byte_cnt_t   byte_cnt;
        logic        up2cpu;
    } read_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;        // final byte of the read
    } rd_byte_t;

    typedef struct packed {
        logic valid;
        crc_t value;
        logic ok;                // value matched expect_crc
    } crc_result_t;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DATA,
        FINISH
    } seq_state_t;

endpackage

// ==== source/ru_reg_if.sv ====
module ru_reg_if (
    input  logic              clk,
    input  logic              rst,
    input  ru_pkg::host_wr_t  host_wr,
    input  logic              busy,
    output ru_pkg::read_req_t read_req,
    output ru_pkg::crc_t      expect_crc
);
    import ru_pkg::*;

    sector_t   start_sector;
    byte_cnt_t byte_cnt;
    logic      up2cpu;
    logic      go_q;         // request pulse, one cycle after the GO write
    logic      ctrl_wr;
    logic      go_hit;

    assign ctrl_wr = host_wr.valid && (host_wr.addr == REG_CTRL);
    assign go_hit  = ctrl_wr && host_wr.data[CTRL_GO] && !busy;   // GO while busy is dropped

    // ------------------------------
    // host registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            start_sector <= '0;
            byte_cnt     <= '0;
            expect_crc   <= '0;
            up2cpu       <= 1'b0;
            go_q         <= 1'b0;
        end else begin
            go_q <= go_hit;
            if (host_wr.valid) begin
                case (host_wr.addr)
                    REG_START_SECTOR: begin
                        start_sector <= host_wr.data[$bits(sector_t)-1:0];
                    end
                    REG_BYTE_CNT: begin
                        byte_cnt <= host_wr.data[$bits(byte_cnt_t)-1:0];
                    end
                    REG_EXPECT_CRC: begin
                        expect_crc <= host_wr.data;
                    end
                    REG_CTRL: begin
                        up2cpu <= host_wr.data[CTRL_UP2CPU];   // held across reads
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // request to the sequencer
    // ------------------------------
    // built from the held registers, which already carry the GO word's up2cpu bit
    always_comb begin
        read_req.valid    = go_q;
        read_req.addr     = flash_addr_t'(start_sector) << SECTOR_SHIFT;   // sector * 4096
        read_req.byte_cnt = byte_cnt;
        read_req.up2cpu   = up2cpu;
    end

endmodule

// ==== source/flash_read_seq.sv ====
module flash_read_seq (
    input  logic              clk,
    input  logic              rst,
    input  ru_pkg::read_req_t read_req,
    output logic [7:0]        tx_byte,
    output logic              tx_start,
    input  logic [7:0]        rx_byte,
    input  logic              byte_done,
    output logic              cs,
    output ru_pkg::rd_byte_t  rd_byte,
    output ru_pkg::rd_byte_t  host_byte,
    input  logic              crc_done,
    output logic              busy
);
    import ru_pkg::*;

    seq_state_t  state;
    flash_addr_t addr_q;
    byte_cnt_t   remain;       // data bytes still to receive
    logic        up2cpu_q;
    logic [1:0]  addr_idx;     // address bytes already on the wire
    logic        last_data;

    assign last_data = (remain == byte_cnt_t'(1));
    assign busy      = (state != IDLE) || read_req.valid;

    // ------------------------------
    // next byte to the shifter
    // ------------------------------
    // issued in the byte_done cycle so bytes follow back to back
    always_comb begin
        tx_start = 1'b0;
        tx_byte  = 8'h00;                       // dummy byte during DATA
        case (state)
            IDLE: begin
                tx_start = read_req.valid;
                tx_byte  = FLASH_CMD_READ;
            end
            CMD: begin
                tx_start = byte_done;
                tx_byte  = addr_q[23:16];       // address msb first
            end
            ADDR: begin
                tx_start = byte_done;
                case (addr_idx)
                    2'd0:    tx_byte = addr_q[15:8];
                    2'd1:    tx_byte = addr_q[7:0];
                    default: tx_byte = 8'h00;   // first dummy
                endcase
            end
            DATA: begin
                tx_start = byte_done && !last_data;
            end
            default: begin
            end
        endcase
    end

    // ------------------------------
    // transaction FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cs       <= 1'b1;
            addr_idx <= 2'd0;
            rd_byte  <= '0;
        end else begin
            rd_byte.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (read_req.valid) begin
                        cs    <= 1'b0;              // opcode starts on the same edge
                        state <= CMD;
                    end
                end
                CMD: begin
                    if (byte_done) begin
                        addr_idx <= 2'd0;
                        state    <= ADDR;
                    end
                end
                ADDR: begin
                    if (byte_done) begin
                        addr_idx <= addr_idx + 2'd1;
                        if (addr_idx == 2'd2) begin
                            state <= DATA;
                        end
                    end
                end
                DATA: begin
                    if (byte_done) begin
                        rd_byte.valid <= 1'b1;
                        rd_byte.data  <= rx_byte;
                        rd_byte.last  <= last_data;
                        if (last_data) begin
                            cs    <= 1'b1;          // sclk drops on this edge too
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    if (crc_done) begin
                        state <= IDLE;              // busy ends with the crc result
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if ((state == IDLE) && read_req.valid) begin
            addr_q   <= read_req.addr;
            remain   <= (read_req.byte_cnt == '0) ? byte_cnt_t'(1) : read_req.byte_cnt;
            up2cpu_q <= read_req.up2cpu;
        end else if ((state == DATA) && byte_done) begin
            remain <= remain - byte_cnt_t'(1);
        end
    end

    always_comb begin
        host_byte       = rd_byte;
        host_byte.valid = rd_byte.valid && up2cpu_q;   // host copy only on request
    end

endmodule

// ==== source/spi_byte_shifter.sv ====
module spi_byte_shifter (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic [7:0] rx_byte,
    output logic       byte_done,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);
    logic       active;
    logic       phase;       // set in the sclk high half
    logic [2:0] bit_cnt;
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic       last_half;
    logic       load;

    assign last_half = active && phase && (bit_cnt == 3'd7);
    assign load      = tx_start && (!active || last_half);   // next byte joins without a gap

    assign byte_done = last_half;
    assign rx_byte   = rx_sr;        // all eight bits sampled by now
    assign mosi      = tx_sr[7];     // msb first

    // ------------------------------
    // sclk and bit timing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            phase   <= 1'b0;
            bit_cnt <= 3'd0;
            sclk    <= 1'b0;
            tx_sr   <= 8'h00;
        end else if (load) begin
            active  <= 1'b1;
            phase   <= 1'b0;
            bit_cnt <= 3'd0;
            sclk    <= 1'b0;
            tx_sr   <= tx_byte;
        end else if (active) begin
            if (!phase) begin
                sclk  <= 1'b1;       // rising edge, flash samples mosi
                phase <= 1'b1;
            end else begin
                sclk    <= 1'b0;     // falling edge, next bit goes out
                phase   <= 1'b0;
                bit_cnt <= bit_cnt + 3'd1;
                tx_sr   <= {tx_sr[6:0], 1'b0};
                if (bit_cnt == 3'd7) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // miso was driven at the previous falling edge, so it is stable here
    always_ff @(posedge clk) begin
        if (active && !phase) begin
            rx_sr <= {rx_sr[6:0], miso};
        end
    end

endmodule

// ==== source/readback_crc32.sv ====
module readback_crc32 (
    input  logic                clk,
    input  logic                rst,
    input  ru_pkg::rd_byte_t    rd_byte,
    input  ru_pkg::crc_t        expect_crc,
    output ru_pkg::crc_result_t crc_result
);
    import ru_pkg::*;

    crc_t crc_q;         // running remainder
    crc_t crc_next;
    crc_t crc_final;

    // one byte through the reflected crc32, lsb first
    function automatic crc_t crc32_byte(input crc_t crc, input logic [7:0] data);
        crc_t c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next  = crc32_byte(crc_q, rd_byte.data);
    assign crc_final = crc_next ^ CRC_INIT;

    // ------------------------------
    // accumulate and report
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q      <= CRC_INIT;
            crc_result <= '0;
        end else begin
            crc_result.valid <= 1'b0;
            if (rd_byte.valid) begin
                if (rd_byte.last) begin
                    crc_result.valid <= 1'b1;
                    crc_result.value <= crc_final;
                    crc_result.ok    <= (crc_final == expect_crc);
                    crc_q            <= CRC_INIT;    // ready for the next read
                end else begin
                    crc_q <= crc_next;
                end
            end
        end
    end

endmodule

// ==== source/remote_update_top.sv ====
module remote_update_top (
    input  logic                clk,
    input  logic                rst,
    input  ru_pkg::host_wr_t    host_wr,
    output ru_pkg::rd_byte_t    host_byte,
    output ru_pkg::crc_result_t crc_result,
    output logic                busy,
    output logic                spi_cs,
    output logic                spi_sclk,
    output logic                spi_mosi,
    input  logic                spi_miso
);
    import ru_pkg::*;

    read_req_t  read_req;
    crc_t       expect_crc;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic [7:0] rx_byte;
    logic       byte_done;
    rd_byte_t   rd_byte;

    // ------------------------------
    // register front end
    // ------------------------------
    ru_reg_if u_reg_if (
        .clk        (clk        ),
        .rst        (rst        ),
        .host_wr    (host_wr    ),
        .busy       (busy       ),
        .read_req   (read_req   ),
        .expect_crc (expect_crc )
    );

    // ------------------------------
    // sequencer and spi engine
    // ------------------------------
    flash_read_seq u_read_seq (
        .clk        (clk              ),
        .rst        (rst              ),
        .read_req   (read_req         ),
        .tx_byte    (tx_byte          ),
        .tx_start   (tx_start         ),
        .rx_byte    (rx_byte          ),
        .byte_done  (byte_done        ),
        .cs         (spi_cs           ),
        .rd_byte    (rd_byte          ),
        .host_byte  (host_byte        ),
        .crc_done   (crc_result.valid ),   // busy ends with the crc result
        .busy       (busy             )
    );

    spi_byte_shifter u_shifter (
        .clk        (clk        ),
        .rst        (rst        ),
        .tx_byte    (tx_byte    ),
        .tx_start   (tx_start   ),
        .rx_byte    (rx_byte    ),
        .byte_done  (byte_done  ),
        .sclk       (spi_sclk   ),
        .mosi       (spi_mosi   ),
        .miso       (spi_miso   )
    );

    // readback check
    readback_crc32 u_crc32 (
        .clk        (clk        ),
        .rst        (rst        ),
        .rd_byte    (rd_byte    ),
        .expect_crc (expect_crc ),
        .crc_result (crc_result )
    );

endmodule

// ==== testbench/flash_model.sv ====
module flash_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso,
    output logic bad_opcode
);
    import ru_pkg::*;

    logic [31:0] cmd_addr = '0;      // opcode then 24-bit address
    int unsigned bit_cnt  = 0;       // rising sclk edges since cs fell
    logic        miso_q   = 1'b0;
    logic        bad_q    = 1'b0;    // sticky

    assign miso       = miso_q;
    assign bad_opcode = bad_q;

    // stored content, one byte per address
    function automatic logic [7:0] pattern(input logic [23:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // ------------------------------
    // command and address decode
    // ------------------------------
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            bit_cnt <= 0;
        end else begin
            if (bit_cnt < 32) begin
                cmd_addr <= {cmd_addr[30:0], mosi};
            end
            if ((bit_cnt == 8) && (cmd_addr[7:0] != FLASH_CMD_READ)) begin
                bad_q <= 1'b1;       // only READ is supported
            end
            bit_cnt <= bit_cnt + 1;
        end
    end

    // data goes out msb first on falling sclk
    always @(negedge sclk) begin : drive_data
        int unsigned idx;
        logic [7:0]  data;
        if (!cs && (bit_cnt >= 32)) begin
            idx    = bit_cnt - 32;
            data   = pattern(cmd_addr[23:0] + 24'(idx / 8));
            miso_q <= data[7 - (idx % 8)];
        end
    end

endmodule

// ==== testbench/remote_update_props.sv ====
module remote_update_props (
    input logic                clk,
    input logic                rst,
    input ru_pkg::host_wr_t    host_wr,
    input ru_pkg::rd_byte_t    host_byte,
    input ru_pkg::crc_result_t crc_result,
    input logic                busy,
    input logic                spi_cs,
    input logic                spi_sclk
);
    import ru_pkg::*;

    logic go_seen;   // a GO write happened since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            go_seen <= 1'b0;
        end else if (host_wr.valid && (host_wr.addr == REG_CTRL) && host_wr.data[CTRL_GO]) begin
            go_seen <= 1'b1;
        end
    end

    // ------------------------------
    // spi and strobe rules
    // ------------------------------
    sclk_low_idle: assert property (@(posedge clk) disable iff (rst) spi_cs |-> !spi_sclk)
        else $error("spi_sclk is high while spi_cs is high");

    crc_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        crc_result.valid |=> !crc_result.valid)
        else $error("crc_result.valid lasted more than one cycle");

    host_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        host_byte.valid |=> !host_byte.valid)
        else $error("host_byte.valid lasted more than one cycle");

    idle_before_go: assert property (@(posedge clk) disable iff (rst)
        !go_seen |-> (spi_cs && !busy))
        else $error("busy or spi_cs active before any GO write");

endmodule

bind remote_update_top remote_update_props u_props (.*);

// ==== testbench/tb_remote_update.sv ====
module tb_remote_update;
    import ru_pkg::*;

    logic        clk;
    logic        rst;
    host_wr_t    host_wr;
    rd_byte_t    host_byte;
    crc_result_t crc_result;
    logic        busy;
    logic        spi_cs;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_miso;
    logic        bad_opcode;

    logic [31:0] lfsr_state = 32'ha48fcf3b;
    rd_byte_t    host_seen[$];       // filled by the monitor
    crc_result_t crc_seen[$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        aborted;            // set after a timeout

    remote_update_top i_dut (
        .clk        (clk        ),
        .rst        (rst        ),
        .host_wr    (host_wr    ),
        .host_byte  (host_byte  ),
        .crc_result (crc_result ),
        .busy       (busy       ),
        .spi_cs     (spi_cs     ),
        .spi_sclk   (spi_sclk   ),
        .spi_mosi   (spi_mosi   ),
        .spi_miso   (spi_miso   )
    );

    flash_model u_flash (
        .cs         (spi_cs     ),
        .sclk       (spi_sclk   ),
        .mosi       (spi_mosi   ),
        .miso       (spi_miso   ),
        .bad_opcode (bad_opcode )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rst && host_byte.valid) host_seen.push_back(host_byte);
        if (!rst && crc_result.valid) crc_seen.push_back(crc_result);
    end

    // ------------------------------
    // reference models
    // ------------------------------
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [7:0] pattern_byte(input flash_addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    // bit-serial reflected crc32 with final inversion
    function automatic crc_t crc32_ref(input logic [7:0] data[$]);
        crc_t c;
        logic fb;
        c = CRC_INIT;
        foreach (data[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ data[k][b];
                c  = c >> 1;
                if (fb) c = c ^ CRC_POLY_REFL;
            end
        end
        return ~c;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_byte(input string what, input rd_byte_t got, input rd_byte_t exp);
        if ((got.data !== exp.data) || (got.last !== exp.last)) begin
            $display("mismatch %s: got data 0x%02h last 0x%0h, expected data 0x%02h last 0x%0h",
                     what, got.data, got.last, exp.data, exp.last);
            errors++;
        end
    endtask

    task automatic check_crc(input string what, input crc_t got, input crc_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_ok(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s count: got 0x%0h expected 0x%0h", what, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // stimulus and tests
    // ------------------------------
    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        host_wr.valid = 1'b1;
        host_wr.addr  = addr;
        host_wr.data  = data;
        @(negedge clk);
        host_wr = '0;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic check_idle();
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if ((spi_cs !== 1'b1) || (busy !== 1'b0) || host_byte.valid || crc_result.valid) begin
                $display("error: output active during idle cycle %0d after reset", i);
                errors++;
            end
        end
        finish_test("idle_after_reset", start_errors);
    endtask

    task automatic run_read(input string name, input sector_t sector, input byte_cnt_t cnt,
                            input logic up2cpu, input logic wrong_crc, input logic go_again);
        int          n;
        int          start_errors;
        int          cycles;
        logic        got_crc;
        logic [7:0]  exp_data[$];
        crc_t        exp_crc;
        flash_addr_t base;
        rd_byte_t    exp_byte;
        logic [31:0] ctrl;
        if (aborted) return;
        start_errors = errors;
        n    = (cnt == '0) ? 1 : int'(cnt);          // zero reads one byte
        base = flash_addr_t'(sector) * 24'd4096;
        for (int i = 0; i < n; i++) exp_data.push_back(pattern_byte(base + flash_addr_t'(i)));
        exp_crc = crc32_ref(exp_data);
        ctrl    = (32'(up2cpu) << CTRL_UP2CPU) | (32'd1 << CTRL_GO);
        host_seen.delete();
        crc_seen.delete();
        write_reg(REG_START_SECTOR, 32'(sector));
        write_reg(REG_BYTE_CNT, 32'(cnt));
        write_reg(REG_EXPECT_CRC, wrong_crc ? ~exp_crc : exp_crc);
        write_reg(REG_CTRL, ctrl);
        cycles  = 0;
        got_crc = 1'b0;
        while (!got_crc && (cycles < (n + 4) * 16 + 64)) begin
            @(negedge clk);
            cycles++;
            got_crc = crc_result.valid;
        end
        if (!got_crc) begin
            $display("error: %s timed out waiting for crc_result.valid", name);
            errors++;
            aborted = 1'b1;
        end else begin
            if (go_again) begin
                check_ok("busy", busy, 1'b1);         // still busy in the result cycle
                host_wr.valid = 1'b1;                 // GO sampled as that cycle ends
                host_wr.addr  = REG_CTRL;
                host_wr.data  = ctrl;
                @(negedge clk);
                host_wr = '0;
                for (int i = 0; i < (n + 4) * 16 + 32; i++) begin
                    @(negedge clk);
                    if ((spi_cs !== 1'b1) || (busy !== 1'b0)) begin
                        $display("error: %s started another read after the ignored GO", name);
                        errors++;
                        break;
                    end
                end
            end else begin
                @(negedge clk);                       // monitor has queued the result
            end
            check_count("host_byte", host_seen.size(), up2cpu ? n : 0);
            check_count("crc_result", crc_seen.size(), 1);
            for (int i = 0; (i < host_seen.size()) && (i < n); i++) begin
                exp_byte.valid = 1'b1;
                exp_byte.data  = exp_data[i];
                exp_byte.last  = (i == n - 1);
                check_byte($sformatf("host_byte[%0d]", i), host_seen[i], exp_byte);
            end
            check_crc("crc_result.value", crc_seen[0].value, exp_crc);
            check_ok("crc_result.ok", crc_seen[0].ok, !wrong_crc);
        end
        if (bad_opcode) begin
            $display("error: flash model received an opcode other than READ");
            errors++;
        end
        finish_test(name, start_errors);
    endtask

    initial begin
        sector_t   sector;
        byte_cnt_t cnt;
        host_wr      = '0;
        rst          = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_idle();
        run_read("read_to_host", 12'h02a, 16'd12, 1'b1, 1'b0, 1'b0);
        run_read("wrong_expect_crc", 12'h02a, 16'd12, 1'b1, 1'b1, 1'b0);
        run_read("crc_only", 12'h7f3, 16'd9, 1'b0, 1'b0, 1'b0);
        run_read("zero_count", 12'h100, 16'd0, 1'b1, 1'b0, 1'b0);
        for (int t = 0; t < 3; t++) begin
            sector = sector_t'(take_bits(12));
            cnt    = byte_cnt_t'(take_bits(4)) + byte_cnt_t'(1);
            run_read($sformatf("go_while_busy_%0d", t), sector, cnt, 1'b1, 1'b0, 1'b1);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/ru_pkg.sv
source/ru_reg_if.sv
source/flash_read_seq.sv
source/spi_byte_shifter.sv
source/readback_crc32.sv
source/remote_update_top.sv
testbench/flash_model.sv
testbench/remote_update_props.sv
testbench/tb_remote_update.sv
